/* src/fir_pkg.sv */
// ********************
// fir package
// sample types, filter size, coefficient table and pipeline latency
// ********************

`default_nettype none

package fir_pkg;

	// ********************
	// widths and sizes
	// ********************

	// samples, folded sums, products and partial sums all wrap at this width
	localparam int SAMPLE_W = 18;

	localparam int NUM_TAPS = 37;

	// 18 mirror pairs plus the center tap
	localparam int NUM_PAIRS = (NUM_TAPS + 1) / 2;

	// enabled cycles from i_sample to o_sample
	// 2 fold + 1 multiply + 4 tree levels + 1 output add
	localparam int LATENCY = 8;

	// ********************
	// types
	// ********************

	// signed sample word, arithmetic keeps the low SAMPLE_W bits
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// signed filter coefficient
	typedef logic signed [SAMPLE_W-1:0] coeff_t;

	// ********************
	// coefficients
	// ********************

	// index k < 18 weights taps k and 36-k
	// index 18 weights the center tap
	localparam coeff_t COEFFS [NUM_PAIRS] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252
	};

endpackage

`default_nettype wire

/* src/fir_tap_fold.sv */
// ********************
// fir tap fold
// input register, delay line and pre-adders that fold mirror taps
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_tap_fold (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             i_clk_ena,
	input  fir_pkg::sample_t      i_sample,
	output fir_pkg::sample_t      o_folded [fir_pkg::NUM_PAIRS]
);

	// tap that has no mirror partner
	localparam int CENTER = fir_pkg::NUM_TAPS / 2;

	fir_pkg::sample_t taps_q [fir_pkg::NUM_TAPS];

	// ********************
	// delay line
	// ********************

	// taps_q[0] is the input register, the rest shift behind it
	// cleared so early windows see zeros
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < fir_pkg::NUM_TAPS; t++) begin
				taps_q[t] <= '0;
			end
		end else if (i_clk_ena) begin
			taps_q[0] <= i_sample;
			for (int t = 1; t < fir_pkg::NUM_TAPS; t++) begin
				taps_q[t] <= taps_q[t-1];
			end
		end
	end

	// ********************
	// pre-adders
	// ********************

	// pair k sums tap k with tap 36-k
	// center tap goes through the same stage to stay aligned
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < CENTER; k++) begin
				o_folded[k] <= taps_q[k] + taps_q[fir_pkg::NUM_TAPS-1-k];
			end
			o_folded[CENTER] <= taps_q[CENTER];
		end
	end

endmodule

`default_nettype wire

/* src/fir_partial_sum.sv */
// ********************
// fir partial sum
// multiplies a slice of folded taps by their coefficients
// and reduces the products in a registered adder tree
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_partial_sum #(
	parameter int FIRST_PAIR = 0,
	parameter int PAIR_COUNT = 1
) (
	input  wire logic             clk,
	input  wire logic             i_clk_ena,
	input  fir_pkg::sample_t      i_folded [fir_pkg::NUM_PAIRS],
	output fir_pkg::sample_t      o_sum
);

	// levels after the multiply stage, 4 for 9 to 16 products
	localparam int DEPTH = $clog2(PAIR_COUNT);

	// number of nodes on a tree level, ceil(PAIR_COUNT / 2**lvl)
	function automatic int level_count(input int lvl);
		return (PAIR_COUNT + (1 << lvl) - 1) >> lvl;
	endfunction

	// row 0 holds the products, row DEPTH the final sum
	// only the first level_count(row) entries of a row are used
	fir_pkg::sample_t node_q [DEPTH+1][PAIR_COUNT];

	genvar lvl;
	genvar idx;

	// ********************
	// multiply stage
	// ********************

	// only the low 18 bits of each product are kept
	generate
		for (idx = 0; idx < PAIR_COUNT; idx++) begin : g_mult
			always_ff @(posedge clk) begin
				if (i_clk_ena) begin
					node_q[0][idx] <= i_folded[FIRST_PAIR + idx] *
						fir_pkg::COEFFS[FIRST_PAIR + idx];
				end
			end
		end
	endgenerate

	// ********************
	// adder tree
	// ********************

	// pairwise sums per level, an odd node at the end takes a bye register
	generate
		for (lvl = 1; lvl <= DEPTH; lvl++) begin : g_level
			for (idx = 0; idx < level_count(lvl); idx++) begin : g_node
				if (2 * idx + 1 < level_count(lvl - 1)) begin : g_add
					always_ff @(posedge clk) begin
						if (i_clk_ena) begin
							node_q[lvl][idx] <= node_q[lvl-1][2*idx] +
								node_q[lvl-1][2*idx+1];
						end
					end
				end else begin : g_bye
					always_ff @(posedge clk) begin
						if (i_clk_ena) begin
							node_q[lvl][idx] <= node_q[lvl-1][2*idx];
						end
					end
				end
			end
		end
	endgenerate

	// single node left on the last level
	assign o_sum = node_q[DEPTH][0];

endmodule

`default_nettype wire

/* src/fir_output_stage.sv */
// ********************
// fir output stage
// final add of both partial sums and the valid delay line
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_output_stage (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             i_clk_ena,
	input  wire logic             i_valid,
	input  fir_pkg::sample_t      i_sum_low,
	input  fir_pkg::sample_t      i_sum_high,
	output fir_pkg::sample_t      o_sample,
	output logic                  o_valid
);

	// one flag per enabled cycle of data latency
	logic [fir_pkg::LATENCY-1:0] valid_q;

	// ********************
	// data
	// ********************

	// wraps modulo 2^18 like the rest of the datapath
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			o_sample <= i_sum_low + i_sum_high;
		end
	end

	// ********************
	// valid
	// ********************

	// advances only with the enable so it stays in step with the data
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[fir_pkg::LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[fir_pkg::LATENCY-1];

endmodule

`default_nettype wire

/* src/fir_top.sv */
// ********************
// fir top
// 37-tap symmetric FIR on 18-bit samples, valid plus clock enable
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_top (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             i_clk_ena,
	input  wire logic             i_valid,
	input  fir_pkg::sample_t      i_sample,
	output fir_pkg::sample_t      o_sample,
	output logic                  o_valid
);

	// pairs 0..9 go to the low slice, 10..18 to the high slice
	// both slices need a 4-level tree so their sums line up
	localparam int SPLIT = 10;

	fir_pkg::sample_t folded [fir_pkg::NUM_PAIRS];
	fir_pkg::sample_t sum_low;
	fir_pkg::sample_t sum_high;

	fir_tap_fold u_tap_fold (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_folded  (folded)
	);

	fir_partial_sum #(
		.FIRST_PAIR (0),
		.PAIR_COUNT (SPLIT)
	) u_sum_low (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_folded  (folded),
		.o_sum     (sum_low)
	);

	fir_partial_sum #(
		.FIRST_PAIR (SPLIT),
		.PAIR_COUNT (fir_pkg::NUM_PAIRS - SPLIT)
	) u_sum_high (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_folded  (folded),
		.o_sum     (sum_high)
	);

	fir_output_stage u_output (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_valid    (i_valid),
		.i_sum_low  (sum_low),
		.i_sum_high (sum_high),
		.o_sample   (o_sample),
		.o_valid    (o_valid)
	);

endmodule

`default_nettype wire

/* bench/fir_sva.sv */
// ********************
// fir output assertions
// reset, enable hold and known valid at the output stage
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_sva (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        i_clk_ena,
	input  fir_pkg::sample_t o_sample,
	input  wire logic        o_valid
);

	// no valid flag survives a reset cycle
	a_valid_after_reset: assert property (@(posedge clk) reset |=> !o_valid)
		else $error("o_valid high in the cycle after reset");

	// a low enable freezes data and valid
	a_hold_when_disabled: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_sample) && $stable(o_valid)
	) else $error("output changed while the clock enable was low");

	a_valid_known: assert property (@(posedge clk) !$isunknown(o_valid))
		else $error("o_valid is unknown");

endmodule

bind fir_output_stage fir_sva u_sva (
	.clk       (clk),
	.reset     (reset),
	.i_clk_ena (i_clk_ena),
	.o_sample  (o_sample),
	.o_valid   (o_valid)
);

`default_nettype wire

/* bench/fir_tb.sv */
// ********************
// fir testbench
// pattern driven stimulus, reference model and result checks for fir_top
// ********************

`default_nettype none
`timescale 1ns/100ps

module fir_tb;

	// first row of the expected impulse response in the pattern file
	localparam int IMPULSE_BASE = 'h80;
	localparam int DRAIN_TIMEOUT = 64;

	logic             clk;
	logic             reset;
	logic             i_clk_ena;
	logic             i_valid;
	fir_pkg::sample_t i_sample;
	fir_pkg::sample_t o_sample;
	logic             o_valid;

	// count(8) enable(4) valid(4) sample(20) per stimulus row
	logic [35:0] patterns [256];

	// newest sample at index 0
	fir_pkg::sample_t history [fir_pkg::NUM_TAPS];
	fir_pkg::sample_t expected_q [$];
	// enabled edge count at the time each expected value was entered
	int               stamp_q [$];
	fir_pkg::sample_t prev_sample;
	logic             prev_valid;
	int               value_errors;
	int               other_errors;
	int               results;
	int               enabled_edges;

	fir_top uut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_sample  (o_sample),
		.o_valid   (o_valid)
	);

	always #2 clk = ~clk;

	// ********************
	// reference model
	// ********************

	// symmetric weights, the table holds the first half and the center
	function automatic fir_pkg::coeff_t tap_weight(input int t);
		if (t < fir_pkg::NUM_PAIRS) begin
			return fir_pkg::COEFFS[t];
		end
		return fir_pkg::COEFFS[fir_pkg::NUM_TAPS-1-t];
	endfunction

	// full sum of weight times history, wrapped to the sample width
	function automatic fir_pkg::sample_t model_output();
		longint acc;
		acc = 0;
		for (int t = 0; t < fir_pkg::NUM_TAPS; t++) begin
			acc += longint'(history[t]) * longint'(tap_weight(t));
		end
		return acc[fir_pkg::SAMPLE_W-1:0];
	endfunction

	task automatic enter_sample(input fir_pkg::sample_t smp, input logic valid);
		for (int t = fir_pkg::NUM_TAPS - 1; t > 0; t--) begin
			history[t] = history[t-1];
		end
		history[0] = smp;
		// invalid samples still shift in but owe no result
		if (valid) begin
			expected_q.push_back(model_output());
			stamp_q.push_back(enabled_edges);
		end
	endtask

	// ********************
	// checks
	// ********************

	task automatic check_outputs(input logic was_enabled);
		fir_pkg::sample_t exp_val;
		int               stamp;
		if (was_enabled) begin
			enabled_edges++;
			assert (!$isunknown(o_valid)) else begin
				$display("o_valid is unknown after an enabled clock edge");
				other_errors++;
			end
			if (o_valid === 1'b1) begin
				assert (expected_q.size() > 0) else begin
					$display("o_valid is high but no valid input is waiting for a result");
					other_errors++;
				end
				if (expected_q.size() > 0) begin
					exp_val = expected_q.pop_front();
					stamp = stamp_q.pop_front();
					assert (enabled_edges - stamp == fir_pkg::LATENCY) else begin
						$display("result came %0d enabled edges after its sample instead of %0d",
							enabled_edges - stamp, fir_pkg::LATENCY);
						other_errors++;
					end
					assert (o_sample === exp_val) else begin
						$display("[FAIL] o_sample: got %h, expected %h", o_sample, exp_val);
						value_errors++;
					end
					// first results come from the impulse at the start of the stream
					if (results < fir_pkg::NUM_TAPS) begin
						assert (o_sample === patterns[IMPULSE_BASE + results][17:0]) else begin
							$display("[FAIL] o_sample impulse word %0d: got %h, expected %h",
								results, o_sample, patterns[IMPULSE_BASE + results][17:0]);
							value_errors++;
						end
					end
					results++;
				end
			end
		end else begin
			// frozen pipeline
			assert (o_sample === prev_sample) else begin
				$display("[FAIL] o_sample held: got %h, expected %h", o_sample, prev_sample);
				value_errors++;
			end
			assert (o_valid === prev_valid) else begin
				$display("[FAIL] o_valid held: got %h, expected %h", o_valid, prev_valid);
				value_errors++;
			end
		end
		prev_sample = o_sample;
		prev_valid = o_valid;
	endtask

	// called on a falling edge, returns on the next one
	task automatic run_cycle(input logic ena, input logic valid, input fir_pkg::sample_t smp);
		i_clk_ena = ena;
		i_valid = valid;
		i_sample = smp;
		if (ena) begin
			enter_sample(smp, valid);
		end
		@(negedge clk);
		check_outputs(ena);
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		int         row;
		int         waited;
		logic [7:0] count;
		clk = 1'b0;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		value_errors = 0;
		other_errors = 0;
		results = 0;
		enabled_edges = 0;
		for (int t = 0; t < fir_pkg::NUM_TAPS; t++) begin
			history[t] = '0;
		end
		$readmemh("bench/fir_patterns.txt", patterns);
		assert (!$isunknown(patterns[0])) else begin
			$display("pattern file bench/fir_patterns.txt could not be read");
			other_errors++;
		end

		repeat (5) begin
			@(negedge clk);
			assert (o_valid === 1'b0) else begin
				$display("[FAIL] o_valid during reset: got %h, expected 0", o_valid);
				value_errors++;
			end
		end
		reset = 1'b0;
		prev_sample = o_sample;
		prev_valid = o_valid;

		row = 0;
		while (row < IMPULSE_BASE && !$isunknown(patterns[row]) &&
				patterns[row][35:28] != 8'h00) begin
			count = patterns[row][35:28];
			repeat (count) begin
				run_cycle(patterns[row][27:24] != 0, patterns[row][23:20] != 0,
					patterns[row][17:0]);
			end
			row++;
		end

		// flush with invalid zeros until every result is out
		waited = 0;
		while (expected_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
			run_cycle(1'b1, 1'b0, '0);
			waited++;
		end
		assert (expected_q.size() == 0) else begin
			$display("timeout: %0d results never appeared on o_valid", expected_q.size());
			other_errors++;
		end

		// nothing valid may follow without a valid input
		repeat (fir_pkg::LATENCY + 2) begin
			run_cycle(1'b1, 1'b0, '0);
		end
		assert (results >= fir_pkg::NUM_TAPS) else begin
			$display("too few results to cover the impulse response");
			other_errors++;
		end

		$display("results %0d, value errors %0d, other errors %0d",
			results, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/fir_patterns.txt */
// each row is count(2) enable(1) valid(1) sample(5) in hex, repeated count cycles
// count 00 ends the stimulus, the rows from @80 hold the 37 expected impulse words
// idle cycles with valid low
031000000
// impulse
011100001
241100000
// step of 1000 with a frozen stretch
3011003e8
0401003e8
1011003e8
// mixed signed samples with full scale values
011120000
01111ffff
011120000
011120000
01113fc18
0301003e8
011100123
01113ff00
011000500
01103ff00
011120000
011000001
01110abcd
05001ffff
01112a5a5
01111ffff
251100000
000000000
@80
00058
00000
3ff9f
3ff3b
3feda
3fe84
3fe41
3fe16
3fe08
3fe1f
3fe5c
3fec1
3ff4e
00000
000d4
001c3
002c6
003d4
004e4
003d4
002c6
001c3
000d4
00000
3ff4e
3fec1
3fe5c
3fe1f
3fe08
3fe16
3fe41
3fe84
3feda
3ff3b
3ff9f
00000
00058

/* files.f */
src/fir_pkg.sv
src/fir_tap_fold.sv
src/fir_partial_sum.sv
src/fir_output_stage.sv
src/fir_top.sv
bench/fir_sva.sv
bench/fir_tb.sv
